//--- hdl/backing_mem.sv
// Backing memory, word addressed, with byte enables.
// Answers each request with an ack pulse after a fixed latency.
`timescale 1ns/1ps

module backing_mem import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_req,
  input  logic [WORD_ADDR_BITS-1:0] i_addr,
  input  logic                      i_we,
  input  logic [XLEN-1:0]           i_wdata,
  input  logic [BYTE_LANES-1:0]     i_be,
  output logic                      o_ack,
  output logic [XLEN-1:0]           o_rdata
);

  logic [XLEN-1:0]     mem_q [MEM_WORDS];
  logic                busy_q;
  logic [LAT_BITS-1:0] cnt_q;
  logic                fire;

  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  assign fire = busy_q && (cnt_q == LAT_BITS'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      o_ack <= 1'b0;
    end else begin
      o_ack <= fire;
      if (fire) begin
        busy_q <= 1'b0;
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
      end else if (i_req && !o_ack) begin
        busy_q <= 1'b1;   // new request seen.
        cnt_q <= LAT_BITS'(MEM_LATENCY - 1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      if (i_we) begin
        for (int b = 0; b < BYTE_LANES; b++) begin
          if (i_be[b]) begin
            mem_q[i_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
          end
        end
      end else begin
        o_rdata <= mem_q[i_addr];
      end
    end
  end

endmodule

//--- hdl/data_cache.sv
// Direct-mapped write-through data cache, one word per line.
// Write misses bypass the cache; read misses fill the line.
`timescale 1ns/1ps

module data_cache import mem_pkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_req,
  input  logic [XLEN-1:0]           i_addr,
  input  logic                      i_op,
  input  logic [2:0]                i_bytes,
  input  logic [XLEN-1:0]           i_wdata,
  input  logic                      i_mem_ack,
  input  logic [XLEN-1:0]           i_mem_rdata,
  output logic                      o_ack,
  output logic [XLEN-1:0]           o_rdata,
  output logic                      o_mem_req,
  output logic [WORD_ADDR_BITS-1:0] o_mem_addr,
  output logic                      o_mem_we,
  output logic [XLEN-1:0]           o_mem_wdata,
  output logic [BYTE_LANES-1:0]     o_mem_be
);

  logic [TAG_BITS-1:0]       tag_q [LINE_COUNT];
  logic [XLEN-1:0]           data_q [LINE_COUNT];
  logic [LINE_COUNT-1:0]     valid_q;
  logic [1:0]                state_q;
  logic [XLEN-1:0]           rdata_q;

  logic [OFFSET_BITS-1:0]    offset;
  logic [INDEX_BITS-1:0]     index;
  logic [TAG_BITS-1:0]       tag;
  logic [5:0]                shamt;
  logic [BYTE_LANES-1:0]     size_mask;
  logic [BYTE_LANES-1:0]     be;
  logic [XLEN-1:0]           wdata_lane;
  logic                      hit;
  logic                      is_write;

  assign offset = i_addr[OFFSET_BITS-1:0];
  assign index = i_addr[OFFSET_BITS +: INDEX_BITS];
  assign tag = i_addr[XLEN-1 -: TAG_BITS];
  assign shamt = {offset, 3'b000};
  assign hit = valid_q[index] && (tag_q[index] == tag);
  assign is_write = (i_op == REQ_WRITE);

  always_comb begin
    case (i_bytes)
      SIZE_B: size_mask = 8'h01;
      SIZE_H: size_mask = 8'h03;
      SIZE_W: size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  assign be = size_mask << offset;
  assign wdata_lane = i_wdata << shamt;

  // memory sees the request already in idle so a miss costs no extra cycle.
  assign o_mem_req = (state_q == CS_MEM) ||
                     ((state_q == CS_IDLE) && i_req && (is_write || !hit));
  assign o_mem_addr = i_addr[OFFSET_BITS +: WORD_ADDR_BITS];
  assign o_mem_we = is_write;
  assign o_mem_wdata = wdata_lane;
  assign o_mem_be = is_write ? be : {BYTE_LANES{1'b1}};

  assign o_ack = (state_q == CS_HIT) || (state_q == CS_DONE);
  assign o_rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= CS_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        CS_IDLE: begin
          if (i_req) begin
            state_q <= (!is_write && hit) ? CS_HIT : CS_MEM;
          end
        end
        CS_MEM: begin
          if (i_mem_ack) begin
            state_q <= CS_DONE;
            if (!is_write) begin
              valid_q[index] <= 1'b1;   // line filled.
            end
          end
        end
        default: state_q <= CS_IDLE;   // ack cycle.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == CS_IDLE && i_req && !is_write && hit) begin
      rdata_q <= data_q[index] >> shamt;
    end
    if (state_q == CS_MEM && i_mem_ack) begin
      if (!is_write) begin
        tag_q[index] <= tag;
        data_q[index] <= i_mem_rdata;
        rdata_q <= i_mem_rdata >> shamt;
      end else if (hit) begin
        for (int b = 0; b < BYTE_LANES; b++) begin
          if (be[b]) begin
            data_q[index][b*8 +: 8] <= wdata_lane[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

//--- hdl/load_extend.sv
// Load extender.
// Sign or zero extends the right-aligned load data by the latched size.
`timescale 1ns/1ps

module load_extend import mem_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_ren,
  input  logic [2:0]      i_bytes,
  input  logic            i_unsigned,
  input  logic [XLEN-1:0] i_raw_rdata,
  output logic [XLEN-1:0] o_rdata
);

  logic [2:0] bytes_q;
  logic       unsigned_q;
  logic       sign;

  always_ff @(posedge clk) begin
    if (rst) begin
      bytes_q <= SIZE_D;
      unsigned_q <= 1'b0;
    end else if (i_start && i_ren) begin
      bytes_q <= i_bytes;
      unsigned_q <= i_unsigned;
    end
  end

  always_comb begin
    sign = 1'b0;
    o_rdata = i_raw_rdata;
    case (bytes_q)
      SIZE_B: begin
        sign = ~unsigned_q & i_raw_rdata[7];
        o_rdata = {{56{sign}}, i_raw_rdata[7:0]};
      end
      SIZE_H: begin
        sign = ~unsigned_q & i_raw_rdata[15];
        o_rdata = {{48{sign}}, i_raw_rdata[15:0]};
      end
      SIZE_W: begin
        sign = ~unsigned_q & i_raw_rdata[31];
        o_rdata = {{32{sign}}, i_raw_rdata[31:0]};
      end
      default: o_rdata = i_raw_rdata;   // full word.
    endcase
  end

endmodule

//--- hdl/mem_pkg.sv
// Memory stage package.
// Word sizes, cache geometry, request codes and memory latency.
package mem_pkg;

  localparam int XLEN = 64;
  localparam int OFFSET_BITS = 3;      // byte offset inside a word.
  localparam int BYTE_LANES = 8;

  localparam logic REQ_READ = 1'b0;
  localparam logic REQ_WRITE = 1'b1;

  localparam int LINE_COUNT = 8;
  localparam int INDEX_BITS = 3;
  localparam int TAG_BITS = XLEN - OFFSET_BITS - INDEX_BITS;

  localparam int MEM_WORDS = 256;
  localparam int WORD_ADDR_BITS = 8;
  localparam int MEM_LATENCY = 3;
  localparam int LAT_BITS = 2;

  // size field is byte count minus one.
  localparam logic [2:0] SIZE_B = 3'd0;
  localparam logic [2:0] SIZE_H = 3'd1;
  localparam logic [2:0] SIZE_W = 3'd3;
  localparam logic [2:0] SIZE_D = 3'd7;

  localparam logic [1:0] CS_IDLE = 2'd0;
  localparam logic [1:0] CS_HIT = 2'd1;
  localparam logic [1:0] CS_MEM = 2'd2;
  localparam logic [1:0] CS_DONE = 2'd3;

endpackage

//--- hdl/mem_stage_top.sv
// Memory stage top level.
// Connects the memory unit, load extender, data cache and backing memory.
`timescale 1ns/1ps

module mem_stage_top import mem_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_ack,
  input  logic [XLEN-1:0] i_addr,
  input  logic [2:0]      i_bytes,
  input  logic            i_ren,
  input  logic            i_wen,
  input  logic            i_unsigned,
  input  logic [XLEN-1:0] i_wdata,
  output logic            o_done,
  output logic [XLEN-1:0] o_rdata
);

  logic [XLEN-1:0]           raw_rdata;
  logic                      dc_req;
  logic [XLEN-1:0]           dc_addr;
  logic                      dc_op;
  logic [2:0]                dc_bytes;
  logic [XLEN-1:0]           dc_wdata;
  logic                      dc_ack;
  logic [XLEN-1:0]           dc_rdata;
  logic                      mem_req;
  logic [WORD_ADDR_BITS-1:0] mem_addr;
  logic                      mem_we;
  logic [XLEN-1:0]           mem_wdata;
  logic [BYTE_LANES-1:0]     mem_be;
  logic                      mem_ack;
  logic [XLEN-1:0]           mem_rdata;

  mem_unit mem_unit_inst (
    .clk, .rst, .i_start, .i_ack, .i_addr, .i_bytes, .i_ren, .i_wen, .i_wdata,
    .i_dcache_ack(dc_ack), .i_dcache_rdata(dc_rdata),
    .o_done, .o_raw_rdata(raw_rdata),
    .o_dcache_req(dc_req), .o_dcache_addr(dc_addr), .o_dcache_op(dc_op),
    .o_dcache_bytes(dc_bytes), .o_dcache_wdata(dc_wdata)
  );

  load_extend load_extend_inst (
    .clk, .rst, .i_start, .i_ren, .i_bytes, .i_unsigned,
    .i_raw_rdata(raw_rdata), .o_rdata
  );

  data_cache data_cache_inst (
    .clk, .rst, .i_req(dc_req), .i_addr(dc_addr), .i_op(dc_op), .i_bytes(dc_bytes),
    .i_wdata(dc_wdata), .i_mem_ack(mem_ack), .i_mem_rdata(mem_rdata),
    .o_ack(dc_ack), .o_rdata(dc_rdata), .o_mem_req(mem_req), .o_mem_addr(mem_addr),
    .o_mem_we(mem_we), .o_mem_wdata(mem_wdata), .o_mem_be(mem_be)
  );

  backing_mem backing_mem_inst (
    .clk, .rst, .i_req(mem_req), .i_addr(mem_addr), .i_we(mem_we),
    .i_wdata(mem_wdata), .i_be(mem_be), .o_ack(mem_ack), .o_rdata(mem_rdata)
  );

endmodule

//--- hdl/mem_unit.sv
// Memory unit.
// Turns a start pulse into a held cache request and a done level.
`timescale 1ns/1ps

module mem_unit import mem_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic            i_start,
  input  logic            i_ack,
  input  logic [XLEN-1:0] i_addr,
  input  logic [2:0]      i_bytes,
  input  logic            i_ren,
  input  logic            i_wen,
  input  logic [XLEN-1:0] i_wdata,
  input  logic            i_dcache_ack,
  input  logic [XLEN-1:0] i_dcache_rdata,
  output logic            o_done,
  output logic [XLEN-1:0] o_raw_rdata,
  output logic            o_dcache_req,
  output logic [XLEN-1:0] o_dcache_addr,
  output logic            o_dcache_op,
  output logic [2:0]      o_dcache_bytes,
  output logic [XLEN-1:0] o_dcache_wdata
);

  logic wait_q;   // access outstanding at the cache.
  logic go;
  logic hs_dcache;

  assign go = i_start & (i_ren | i_wen);
  assign hs_dcache = wait_q & i_dcache_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wait_q <= 1'b0;
      o_dcache_req <= 1'b0;
      o_done <= 1'b0;
    end else begin
      if (go) begin
        wait_q <= 1'b1;
        o_dcache_req <= 1'b1;
      end else if (hs_dcache) begin
        wait_q <= 1'b0;
        o_dcache_req <= 1'b0;
        o_done <= 1'b1;
      end else if (o_done && i_ack) begin
        o_done <= 1'b0;   // pipeline took the result.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      o_dcache_op <= i_ren ? REQ_READ : REQ_WRITE;   // read wins over write.
      o_dcache_addr <= i_addr;
      o_dcache_bytes <= i_bytes;
      o_dcache_wdata <= i_wdata;
    end
    if (hs_dcache) begin
      o_raw_rdata <= i_dcache_rdata;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the memory stage testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_mem_stage -f sources.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_mem_stage +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

//--- sim/mem_stage_assert.sv
// Handshake checks for a req level / ack pulse port.
// The done level part is tied off where a block has none.
`timescale 1ns/1ps

module mem_stage_assert import mem_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            i_req,
  input logic            i_ack,
  input logic [XLEN-1:0] i_addr,
  input logic            i_op,
  input logic [7:0]      i_ctl,
  input logic [XLEN-1:0] i_wdata,
  input logic            i_done,
  input logic            i_done_ack,
  input logic [XLEN-1:0] i_done_data
);

  int fail_count = 0;

  reset_idle: assert property (@(posedge clk) $fell(rst) |-> !i_req && !i_ack && !i_done)
    else begin
      fail_count++;
      $error("request, ack or done high at the end of reset");
    end

  req_held: assert property (@(posedge clk) disable iff (rst)
    i_req && !i_ack |=> i_req && $stable(i_addr) && $stable(i_op) &&
                         $stable(i_ctl) && $stable(i_wdata))
    else begin
      fail_count++;
      $error("request dropped or changed before its ack");
    end

  req_drop: assert property (@(posedge clk) disable iff (rst) i_req && i_ack |=> !i_req)
    else begin
      fail_count++;
      $error("request still high the cycle after its ack");
    end

  ack_pulse: assert property (@(posedge clk) disable iff (rst) i_ack |-> i_req ##1 !i_ack)
    else begin
      fail_count++;
      $error("ack without a request or longer than one cycle");
    end

  done_held: assert property (@(posedge clk) disable iff (rst)
    i_done && !i_done_ack |=> i_done && $stable(i_done_data))
    else begin
      fail_count++;
      $error("done dropped or its data changed before the pipeline ack");
    end

  done_drop: assert property (@(posedge clk) disable iff (rst) i_done && i_done_ack |=> !i_done)
    else begin
      fail_count++;
      $error("done still high the cycle after the pipeline ack");
    end

endmodule

bind mem_unit mem_stage_assert unit_chk (
  .clk, .rst, .i_req(o_dcache_req), .i_ack(i_dcache_ack), .i_addr(o_dcache_addr),
  .i_op(o_dcache_op), .i_ctl({5'd0, o_dcache_bytes}), .i_wdata(o_dcache_wdata),
  .i_done(o_done), .i_done_ack(i_ack), .i_done_data(o_raw_rdata)
);

bind data_cache mem_stage_assert cache_chk (
  .clk, .rst, .i_req(o_mem_req), .i_ack(i_mem_ack), .i_addr({56'd0, o_mem_addr}),
  .i_op(o_mem_we), .i_ctl(o_mem_be), .i_wdata(o_mem_wdata),
  .i_done(1'b0), .i_done_ack(1'b0), .i_done_data(64'd0)
);

//--- sim/tb_mem_stage.sv
// Testbench for the memory stage.
// Random loads and stores checked against a byte-level memory model.
`timescale 1ns/1ps

module tb_mem_stage import mem_pkg::*; ();

  localparam int NUM_OPS = 200;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 16 + 20;
  localparam logic [2:0] SIZES [4] = '{SIZE_B, SIZE_H, SIZE_W, SIZE_D};

  logic            clk;
  logic            rst;
  logic            i_start;
  logic            i_ack;
  logic [XLEN-1:0] i_addr;
  logic [2:0]      i_bytes;
  logic            i_ren;
  logic            i_wen;
  logic            i_unsigned;
  logic [XLEN-1:0] i_wdata;
  logic            o_done;
  logic [XLEN-1:0] o_rdata;

  logic [7:0] model_mem [MEM_WORDS*8];   // byte image of the backing memory.
  int errors = 0;
  int loads_checked = 0;
  int cycles = 0;

  mem_stage_top mem_stage_top_inst (
    .clk, .rst, .i_start, .i_ack, .i_addr, .i_bytes, .i_ren, .i_wen,
    .i_unsigned, .i_wdata, .o_done, .o_rdata
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles, %0d data errors so far", cycles, errors);
      $display("Checks failed");
      $finish;
    end
  end

  // little-endian bytes from the model, extended from the top loaded byte.
  function automatic logic [XLEN-1:0] expected_load(input int addr, input logic [2:0] bytes,
                                                    input logic unsgn);
    logic [XLEN-1:0] val;
    logic            sign;
    sign = !unsgn && model_mem[addr + int'(bytes)][7];
    for (int i = 0; i < 8; i++) begin
      if (i <= int'(bytes)) begin
        val[i*8 +: 8] = model_mem[addr + i];
      end else begin
        val[i*8 +: 8] = {8{sign}};
      end
    end
    return val;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic run_access(input logic store, input int addr, input logic [2:0] bytes,
                            input logic unsgn, input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] expected;
    expected = expected_load(addr, bytes, unsgn);
    next_cycle();
    i_start = 1'b1;
    i_ren = !store;
    i_wen = store;
    i_addr = XLEN'(addr);
    i_bytes = bytes;
    i_unsigned = unsgn;
    i_wdata = wdata;
    next_cycle();
    i_start = 1'b0;
    i_ren = 1'b0;
    i_wen = 1'b0;
    while (!o_done) begin
      next_cycle();
    end
    if (store) begin
      for (int i = 0; i <= int'(bytes); i++) begin
        model_mem[addr + i] = wdata[i*8 +: 8];
      end
    end else begin
      loads_checked++;
      assert (o_rdata == expected) else begin
        errors++;
        $display("FAILED at %0t: o_rdata expected %h, got %h", $time, expected, o_rdata);
      end
    end
    repeat ($urandom_range(0, 3)) next_cycle();
    i_ack = 1'b1;
    next_cycle();
    i_ack = 1'b0;
  endtask

  initial begin
    logic [2:0] bytes;
    logic [2:0] offset;
    int         addr;
    int         proto_errors;
    void'($urandom(32'h6bc53756));
    rst = 1'b1;
    i_start = 1'b0;
    i_ack = 1'b0;
    i_addr = '0;
    i_bytes = SIZE_D;
    i_ren = 1'b0;
    i_wen = 1'b0;
    i_unsigned = 1'b0;
    i_wdata = '0;
    for (int i = 0; i < MEM_WORDS * 8; i++) begin
      model_mem[i] = 8'h00;
    end
    repeat (10) @(posedge clk);
    #2 rst = 1'b0;
    for (int n = 0; n < NUM_OPS; n++) begin
      bytes = SIZES[$urandom_range(0, 3)];
      offset = 3'($urandom_range(0, 7)) & ~bytes;   // natural alignment.
      addr = int'($urandom_range(0, 31)) * 8 + int'(offset);   // 32 words, 4 per index.
      run_access(1'($urandom_range(0, 1)), addr, bytes, 1'($urandom_range(0, 1)),
                 {$urandom, $urandom});
    end
    next_cycle();
    next_cycle();
    proto_errors = mem_stage_top_inst.mem_unit_inst.unit_chk.fail_count +
                   mem_stage_top_inst.data_cache_inst.cache_chk.fail_count;
    $display("%0d loads checked, %0d data errors, %0d protocol errors",
             loads_checked, errors, proto_errors);
    if (errors == 0 && proto_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- sources.f
hdl/mem_pkg.sv
hdl/mem_unit.sv
hdl/load_extend.sv
hdl/data_cache.sv
hdl/backing_mem.sv
hdl/mem_stage_top.sv
sim/mem_stage_assert.sv
sim/tb_mem_stage.sv
